//--- bench/tb_osd_mam_wb.sv
// Testbench of the debug memory access module; drives request packets and checks every response
`timescale 1ns/1ps
`include "mam_cfg.svh"

module tb_osd_mam_wb;

   localparam int                NPKT   = 32;
   localparam mam_pkg::node_id_t OWN_ID = 10'h025;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic              debug_in_valid_i;
   logic              debug_in_last_i;
   mam_pkg::flit_t    debug_in_data_i;
   logic              debug_in_ready_o;
   logic              debug_out_valid_o;
   logic              debug_out_last_o;
   mam_pkg::flit_t    debug_out_data_o;
   logic              debug_out_ready_i;
   logic              cyc_o;
   logic              stb_o;
   logic              we_o;
   mam_pkg::addr_t    addr_o;
   mam_pkg::flit_t    dat_o;
   mam_pkg::flit_t    dat_i;
   logic              ack_i;

   logic [31:0]       lfsr_q = 32'h7856;

   // Test packets, built before reset
   mam_pkg::node_id_t pk_dest [0:NPKT-1];
   mam_pkg::node_id_t pk_src [0:NPKT-1];
   logic              pk_we [0:NPKT-1];
   mam_pkg::addr_t    pk_addr [0:NPKT-1];
   mam_pkg::beats_t   pk_beats [0:NPKT-1];
   mam_pkg::flit_t    pk_data [0:NPKT-1][0:`MAM_MAX_BEATS];
   int                pk_count = 0;
   logic              tests_ready = 1'b0;

   // Slave memory and the copy kept by the stimulus
   mam_pkg::flit_t    mem [0:255];
   mam_pkg::flit_t    mirror [0:255];
   logic              slave_busy;
   logic [1:0]        wait_left;

   mam_pkg::flit_t    exp_data_q[$];
   logic              exp_last_q[$];
   mam_pkg::flit_t    rx_data_q[$];
   logic              rx_last_q[$];

   int                bus_beats = 0;
   int                exp_beats = 0;
   int                rsp_count = 0;
   int                err_flit = 0;
   int                err_last = 0;
   int                err_count = 0;
   int                err_other = 0;

   always #5 clk_i = ~clk_i;

   osd_mam_wb dut_i (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .debug_in_valid_i  (debug_in_valid_i),
      .debug_in_last_i   (debug_in_last_i),
      .debug_in_data_i   (debug_in_data_i),
      .debug_in_ready_o  (debug_in_ready_o),
      .debug_out_valid_o (debug_out_valid_o),
      .debug_out_last_o  (debug_out_last_o),
      .debug_out_data_o  (debug_out_data_o),
      .debug_out_ready_i (debug_out_ready_i),
      .id_i              (OWN_ID),
      .cyc_o             (cyc_o),
      .stb_o             (stb_o),
      .we_o              (we_o),
      .addr_o            (addr_o),
      .dat_o             (dat_o),
      .dat_i             (dat_i),
      .ack_i             (ack_i)
   );

   // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return r;
   endfunction

   // Expected flit idx of the response to one accepted request
   function automatic mam_pkg::flit_t ref_flit(input logic we, input mam_pkg::node_id_t src,
                                               input mam_pkg::addr_t addr, input int idx);
      mam_pkg::addr_t a;
      a = addr + mam_pkg::addr_t'(2 * (idx - 3));
      if (idx == 0) begin
         return mam_pkg::flit_t'(src);
      end else if (idx == 1) begin
         return mam_pkg::flit_t'(OWN_ID);
      end else if (idx == 2) begin
         return we ? `MAM_RSP_WRITE : `MAM_RSP_READ;
      end
      return mirror[a[8:1]];
   endfunction

   task automatic check_flit(input string name, input mam_pkg::flit_t exp,
                             input mam_pkg::flit_t got);
      if (got !== exp) begin
         err_flit++;
         $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   task automatic check_last(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         err_last++;
         $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int got);
      if (got != exp) begin
         err_count++;
         $display("** Error: %s expected %h got %h", name, exp, got);
      end
   endtask

   task automatic add_pkt(input mam_pkg::node_id_t dest, input logic we,
                          input mam_pkg::addr_t addr, input mam_pkg::beats_t beats);
      int k;
      pk_dest[pk_count]  = dest;
      pk_src[pk_count]   = mam_pkg::node_id_t'(rand_bits(10));
      pk_we[pk_count]    = we;
      pk_addr[pk_count]  = addr;
      pk_beats[pk_count] = beats;
      for (k = 0; k <= `MAM_MAX_BEATS; k++) begin
         pk_data[pk_count][k] = mam_pkg::flit_t'(rand_bits(16));
      end
      pk_count++;
   endtask

   task automatic build_tests();
      mam_pkg::addr_t  a0;
      mam_pkg::addr_t  a;
      mam_pkg::beats_t b;
      int              i;
      a0 = rand_bits(32) & ~mam_pkg::addr_t'(1);
      // Single-beat write, then read back
      add_pkt(OWN_ID, 1'b1, a0, mam_pkg::beats_t'(1));
      add_pkt(OWN_ID, 1'b0, a0, mam_pkg::beats_t'(1));
      // Multi-beat write and read of the same block
      for (i = 0; i < 6; i++) begin
         a = rand_bits(32) & ~mam_pkg::addr_t'(1);
         b = (i == 0) ? mam_pkg::beats_t'(`MAM_MAX_BEATS) :
                        mam_pkg::beats_t'(2 + (rand_bits(4) % 15));
         add_pkt(OWN_ID, 1'b1, a, b);
         add_pkt(OWN_ID, 1'b0, a, b);
      end
      // Foreign destination, then a normal request
      add_pkt(10'h026, 1'b1, a0, mam_pkg::beats_t'(2));
      add_pkt(OWN_ID, 1'b0, a0, mam_pkg::beats_t'(1));
      // Beat counts out of range
      add_pkt(OWN_ID, 1'b0, a0, mam_pkg::beats_t'(0));
      add_pkt(OWN_ID, 1'b1, a0, mam_pkg::beats_t'(`MAM_MAX_BEATS + 1));
      add_pkt(OWN_ID, 1'b0, a0, mam_pkg::beats_t'(1));
      // Random mix
      for (i = 0; i < 10; i++) begin
         a = rand_bits(32) & ~mam_pkg::addr_t'(1);
         add_pkt(OWN_ID, rand_bits(1) != 0, a, mam_pkg::beats_t'(1 + rand_bits(4)));
      end
      tests_ready = 1'b1;
   endtask

   // Flit is taken on the rising edge where ready was seen
   task automatic send_flit(input mam_pkg::flit_t data, input logic last);
      @(negedge clk_i);
      debug_in_valid_i = 1'b1;
      debug_in_data_i  = data;
      debug_in_last_i  = last;
      #1;
      while (!debug_in_ready_o) begin
         @(negedge clk_i);
         #1;
      end
      @(posedge clk_i);
   endtask

   task automatic send_packet(input int p);
      mam_pkg::addr_t a;
      logic           accepted;
      logic           has_data;
      int             n;
      int             k;
      accepted = (pk_dest[p] == OWN_ID) && (pk_beats[p] != '0) &&
                 (pk_beats[p] <= mam_pkg::beats_t'(`MAM_MAX_BEATS));
      has_data = pk_we[p] && (pk_beats[p] != '0);
      if (accepted) begin
         if (pk_we[p]) begin
            for (k = 0; k < int'(pk_beats[p]); k++) begin
               a = pk_addr[p] + mam_pkg::addr_t'(2 * k);
               mirror[a[8:1]] = pk_data[p][k];
            end
         end
         n = pk_we[p] ? 3 : 3 + int'(pk_beats[p]);
         for (k = 0; k < n; k++) begin
            exp_data_q.push_back(ref_flit(pk_we[p], pk_src[p], pk_addr[p], k));
            exp_last_q.push_back(k == n - 1);
         end
         exp_beats += int'(pk_beats[p]);
      end
      send_flit(mam_pkg::flit_t'(pk_dest[p]), 1'b0);
      send_flit(mam_pkg::flit_t'(pk_src[p]), 1'b0);
      send_flit({pk_we[p], 1'b0, pk_beats[p]}, 1'b0);
      send_flit(pk_addr[p][31:16], 1'b0);
      send_flit(pk_addr[p][15:0], !has_data);
      if (has_data) begin
         for (k = 0; k < int'(pk_beats[p]); k++) begin
            send_flit(pk_data[p][k], k == int'(pk_beats[p]) - 1);
         end
      end
      @(negedge clk_i);
      debug_in_valid_i = 1'b0;
      debug_in_last_i  = 1'b0;
   endtask

   task automatic compare_packet();
      mam_pkg::flit_t got;
      logic           got_last;
      while (rx_data_q.size() > 0) begin
         got      = rx_data_q.pop_front();
         got_last = rx_last_q.pop_front();
         if (exp_data_q.size() == 0) begin
            err_other++;
            $display("Response flit %h arrived while no response was expected", got);
         end else begin
            check_flit("debug_out_data_o", exp_data_q.pop_front(), got);
            check_last("debug_out_last_o", exp_last_q.pop_front(), got_last);
         end
      end
      rsp_count++;
   endtask

   // Wishbone slave with random wait states, and random output back-pressure
   always @(negedge clk_i) begin
      debug_out_ready_i = (rand_bits(2) != 0);
      if (rst_i || ack_i) begin
         ack_i      = 1'b0;
         slave_busy = 1'b0;
      end else if (cyc_o && stb_o) begin
         if (!slave_busy) begin
            slave_busy = 1'b1;
            wait_left  = 2'(rand_bits(2));
         end
         if (wait_left == 2'd0) begin
            ack_i = 1'b1;
            bus_beats++;
            if (we_o) begin
               mem[addr_o[8:1]] = dat_o;
            end else begin
               dat_i = mem[addr_o[8:1]];
            end
         end else begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

   // Output flits collected where they are stable before the taking edge
   always @(negedge clk_i) begin
      #1;
      if (!rst_i && debug_out_valid_o && debug_out_ready_i) begin
         rx_data_q.push_back(debug_out_data_o);
         rx_last_q.push_back(debug_out_last_o);
         if (debug_out_last_o) begin
            compare_packet();
         end
      end
   end

   initial begin
      wait (tests_ready);
      repeat (200 * pk_count + 1000) @(posedge clk_i);
      $display("Timeout after %0d cycles, responses still missing", 200 * pk_count + 1000);
      $display("Verification failed");
      $finish;
   end

   initial begin
      int i;
      rst_i             = 1'b1;
      debug_in_valid_i  = 1'b0;
      debug_in_last_i   = 1'b0;
      debug_in_data_i   = '0;
      debug_out_ready_i = 1'b0;
      dat_i             = '0;
      ack_i             = 1'b0;
      slave_busy        = 1'b0;
      wait_left         = 2'd0;
      for (i = 0; i < 256; i++) begin
         mem[i]    = {8'(i), ~8'(i)};
         mirror[i] = {8'(i), ~8'(i)};
      end
      build_tests();
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      for (i = 0; i < pk_count; i++) begin
         send_packet(i);
      end
      while (exp_data_q.size() != 0) begin
         @(negedge clk_i);
      end
      // Quiet period to catch stray responses
      repeat (50) @(negedge clk_i);
      if (rx_data_q.size() != 0) begin
         err_other++;
         $display("A response packet was left without its last flit");
      end
      check_count("bus beat count", exp_beats, bus_beats);
      $display("Errors: flit %0d, last %0d, count %0d, other %0d over %0d responses",
               err_flit, err_last, err_count, err_other, rsp_count);
      if (err_flit + err_last + err_count + err_other == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- hdl/mam_cfg.svh
// Widths, beat limit and response codes of the memory access module, included by RTL and bench
`ifndef MAM_CFG_SVH
`define MAM_CFG_SVH

// Flit and bus data width
`define MAM_DATA_WIDTH 16

// Wishbone byte address width
`define MAM_ADDR_WIDTH 32

// Largest beat count a request may carry
`define MAM_MAX_BEATS 16

// Code word of a response packet
`define MAM_RSP_READ  16'h0001
`define MAM_RSP_WRITE 16'h0002

`endif

//--- hdl/mam_pkg.sv
// Common vector types and decoder states of the memory access module, used by scoped name
`include "mam_cfg.svh"

package mam_pkg;

   // One stream flit, also one bus data word
   typedef logic [`MAM_DATA_WIDTH-1:0] flit_t;

   typedef logic [`MAM_ADDR_WIDTH-1:0] addr_t;

   // Debug node id, low bits of an id word
   typedef logic [9:0] node_id_t;

   // Beat count field of a request header
   typedef logic [13:0] beats_t;

   // Request parser states
   typedef enum logic [2:0] {
      DEST,
      SRC,
      HDR,
      ADDR_HI,
      ADDR_LO,
      WDATA,
      DROP,
      WAIT_REQ
   } dec_state_t;

endpackage

//--- hdl/mam_req_decode.sv
// Request parser of the memory access module; turns incoming flits into a request and write words
`timescale 1ns/1ps
`include "mam_cfg.svh"

module mam_req_decode (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              in_valid_i,
   input  logic              in_last_i,
   input  mam_pkg::flit_t    in_data_i,
   output logic              in_ready_o,
   input  mam_pkg::node_id_t id_i,
   output logic              req_valid_o,
   input  logic              req_ready_i,
   output logic              req_we_o,
   output mam_pkg::addr_t    req_addr_o,
   output mam_pkg::beats_t   req_beats_o,
   output mam_pkg::node_id_t req_src_o,
   output logic              wr_valid_o,
   input  logic              wr_ready_i,
   output mam_pkg::flit_t    wr_data_o
);

   mam_pkg::dec_state_t state_q;
   mam_pkg::dec_state_t state_d;
   logic                in_xfer;
   logic                beats_bad;
   mam_pkg::beats_t     hdr_beats;
   mam_pkg::beats_t     wr_cnt_q;
   logic                req_we_q;
   mam_pkg::addr_t      req_addr_q;
   mam_pkg::beats_t     req_beats_q;
   mam_pkg::node_id_t   req_src_q;

   // Stalled while a request waits; follows execute during write data
   always_comb begin
      case (state_q)
         mam_pkg::WAIT_REQ: in_ready_o = 1'b0;
         mam_pkg::WDATA:    in_ready_o = wr_ready_i;
         default:           in_ready_o = 1'b1;
      endcase
   end

   assign in_xfer   = in_valid_i && in_ready_o;
   assign hdr_beats = in_data_i[13:0];
   assign beats_bad = (hdr_beats == '0) || (hdr_beats > mam_pkg::beats_t'(`MAM_MAX_BEATS));

   always_comb begin
      state_d = state_q;
      case (state_q)
         mam_pkg::DEST: begin
            // A single-flit packet is simply consumed
            if (in_xfer && !in_last_i) begin
               if (in_data_i[9:0] == id_i) begin
                  state_d = mam_pkg::SRC;
               end else begin
                  state_d = mam_pkg::DROP;
               end
            end
         end
         mam_pkg::SRC: begin
            if (in_xfer) begin
               state_d = in_last_i ? mam_pkg::DEST : mam_pkg::HDR;
            end
         end
         mam_pkg::HDR: begin
            if (in_xfer) begin
               if (in_last_i) begin
                  state_d = mam_pkg::DEST;
               end else if (beats_bad) begin
                  state_d = mam_pkg::DROP;
               end else begin
                  state_d = mam_pkg::ADDR_HI;
               end
            end
         end
         mam_pkg::ADDR_HI: begin
            if (in_xfer) begin
               state_d = in_last_i ? mam_pkg::DEST : mam_pkg::ADDR_LO;
            end
         end
         mam_pkg::ADDR_LO: begin
            if (in_xfer) begin
               state_d = mam_pkg::WAIT_REQ;
            end
         end
         mam_pkg::WAIT_REQ: begin
            if (req_ready_i) begin
               state_d = req_we_q ? mam_pkg::WDATA : mam_pkg::DEST;
            end
         end
         mam_pkg::WDATA: begin
            // Surplus data words are drained with the rest of the packet
            if (in_xfer && (wr_cnt_q == mam_pkg::beats_t'(1))) begin
               state_d = in_last_i ? mam_pkg::DEST : mam_pkg::DROP;
            end
         end
         mam_pkg::DROP: begin
            if (in_xfer && in_last_i) begin
               state_d = mam_pkg::DEST;
            end
         end
         default: state_d = mam_pkg::DEST;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= mam_pkg::DEST;
      end else begin
         state_q <= state_d;
      end
   end

   // Request fields captured word by word
   always_ff @(posedge clk_i) begin
      if (in_xfer) begin
         case (state_q)
            mam_pkg::SRC: req_src_q <= in_data_i[9:0];
            mam_pkg::HDR: begin
               req_we_q    <= in_data_i[15];
               req_beats_q <= hdr_beats;
            end
            mam_pkg::ADDR_HI: req_addr_q[`MAM_ADDR_WIDTH-1:`MAM_DATA_WIDTH] <= in_data_i;
            mam_pkg::ADDR_LO: req_addr_q[`MAM_DATA_WIDTH-1:0] <= in_data_i;
            mam_pkg::WDATA:   wr_cnt_q <= wr_cnt_q - mam_pkg::beats_t'(1);
            default: ;
         endcase
      end
      if ((state_q == mam_pkg::WAIT_REQ) && req_ready_i) begin
         wr_cnt_q <= req_beats_q;
      end
   end

   assign req_valid_o = (state_q == mam_pkg::WAIT_REQ);
   assign req_we_o    = req_we_q;
   assign req_addr_o  = req_addr_q;
   assign req_beats_o = req_beats_q;
   assign req_src_o   = req_src_q;

   // Write words pass straight from the stream to execute
   assign wr_valid_o = in_valid_i && (state_q == mam_pkg::WDATA);
   assign wr_data_o  = in_data_i;

   // Execute takes a write word only while one is forwarded from the stream
   a_wr_taken_forwarded: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_ready_i |-> wr_valid_o);

endmodule

//--- hdl/mam_resp_encode.sv
// Result stage of the memory access module; sends response packets on the outgoing flit stream
`timescale 1ns/1ps
`include "mam_cfg.svh"

module mam_resp_encode (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              rsp_start_i,
   input  logic              rsp_we_i,
   input  mam_pkg::node_id_t rsp_dest_i,
   input  mam_pkg::beats_t   beats_i,
   input  mam_pkg::node_id_t id_i,
   input  logic              rd_valid_i,
   output logic              rd_ready_o,
   input  mam_pkg::flit_t    rd_data_i,
   output logic              out_valid_o,
   input  logic              out_ready_i,
   output logic              out_last_o,
   output mam_pkg::flit_t    out_data_o
);

   logic              busy_q;
   logic [1:0]        phase_q;
   logic              buf_valid_q;
   mam_pkg::beats_t   rx_left_q;
   mam_pkg::beats_t   tx_left_q;
   logic              we_q;
   mam_pkg::node_id_t dest_q;
   mam_pkg::flit_t    buf_q;
   logic              out_xfer;
   logic              rd_xfer;
   logic              data_phase;

   // Phases 0 to 2 are the header words, phase 3 carries read data
   assign data_phase = (phase_q == 2'd3);

   assign out_valid_o = busy_q && (!data_phase || buf_valid_q);
   assign out_last_o  = ((phase_q == 2'd2) && we_q) ||
                        (data_phase && (tx_left_q == mam_pkg::beats_t'(1)));
   assign out_xfer    = out_valid_o && out_ready_i;

   always_comb begin
      case (phase_q)
         2'd0:    out_data_o = mam_pkg::flit_t'(dest_q);
         2'd1:    out_data_o = mam_pkg::flit_t'(id_i);
         2'd2:    out_data_o = we_q ? `MAM_RSP_WRITE : `MAM_RSP_READ;
         default: out_data_o = buf_q;
      endcase
   end

   // High while idle so execute knows a new response may start
   assign rd_ready_o = busy_q ? (!buf_valid_q && (rx_left_q != '0)) : 1'b1;
   assign rd_xfer    = rd_valid_i && rd_ready_o && busy_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q      <= 1'b0;
         phase_q     <= 2'd0;
         buf_valid_q <= 1'b0;
         rx_left_q   <= '0;
         tx_left_q   <= '0;
      end else begin
         if (!busy_q && rsp_start_i) begin
            busy_q    <= 1'b1;
            phase_q   <= 2'd0;
            rx_left_q <= rsp_we_i ? '0 : beats_i;
            tx_left_q <= rsp_we_i ? '0 : beats_i;
         end
         if (rd_xfer) begin
            buf_valid_q <= 1'b1;
            rx_left_q   <= rx_left_q - mam_pkg::beats_t'(1);
         end
         if (out_xfer) begin
            if (out_last_o) begin
               busy_q <= 1'b0;
            end else if (!data_phase) begin
               phase_q <= phase_q + 2'd1;
            end
            if (data_phase) begin
               buf_valid_q <= 1'b0;
               tx_left_q   <= tx_left_q - mam_pkg::beats_t'(1);
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!busy_q && rsp_start_i) begin
         we_q   <= rsp_we_i;
         dest_q <= rsp_dest_i;
      end
      if (rd_xfer) begin
         buf_q <= rd_data_i;
      end
   end

   // Offered flit holds until the sink takes it
   a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

//--- hdl/mam_wb_master.sv
// Execute stage of the memory access module; runs one classic Wishbone cycle per beat
`timescale 1ns/1ps

module mam_wb_master (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              req_valid_i,
   output logic              req_ready_o,
   input  logic              req_we_i,
   input  mam_pkg::addr_t    req_addr_i,
   input  mam_pkg::beats_t   req_beats_i,
   input  mam_pkg::node_id_t req_src_i,
   input  logic              wr_valid_i,
   output logic              wr_ready_o,
   input  mam_pkg::flit_t    wr_data_i,
   output logic              rsp_start_o,
   output logic              rsp_we_o,
   output mam_pkg::node_id_t rsp_dest_o,
   output logic              rd_valid_o,
   input  logic              rd_ready_i,
   output mam_pkg::flit_t    rd_data_o,
   output logic              cyc_o,
   output logic              stb_o,
   output logic              we_o,
   output mam_pkg::addr_t    addr_o,
   output mam_pkg::flit_t    dat_o,
   input  mam_pkg::flit_t    dat_i,
   input  logic              ack_i
);

   mam_pkg::beats_t   cnt_q;
   logic              cyc_q;
   logic              rd_valid_q;
   logic              rsp_start_q;
   logic              we_q;
   mam_pkg::addr_t    addr_q;
   mam_pkg::node_id_t src_q;
   mam_pkg::flit_t    rd_data_q;
   logic              busy;
   logic              req_xfer;
   logic              bus_start;
   logic              bus_done;

   assign busy = (cnt_q != '0);

   // A new request waits until result is idle again, which rd_ready_i signals outside a response
   assign req_ready_o = !busy && !rsp_start_q && !rd_valid_q && rd_ready_i;
   assign req_xfer    = req_valid_i && req_ready_o;

   // Writes need a data word, reads need a free handoff register
   assign bus_start = busy && !cyc_q && (we_q ? wr_valid_i : !rd_valid_q);
   assign bus_done  = cyc_q && ack_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q       <= '0;
         cyc_q       <= 1'b0;
         rd_valid_q  <= 1'b0;
         rsp_start_q <= 1'b0;
      end else begin
         // Reads announce their response right after acceptance
         rsp_start_q <= req_xfer && !req_we_i;
         if (req_xfer) begin
            cnt_q <= req_beats_i;
         end
         if (bus_start) begin
            cyc_q <= 1'b1;
         end
         if (bus_done) begin
            cyc_q <= 1'b0;
            cnt_q <= cnt_q - mam_pkg::beats_t'(1);
            if (!we_q) begin
               rd_valid_q <= 1'b1;
            end
            // Writes are answered once the last beat is on the bus
            if (we_q && (cnt_q == mam_pkg::beats_t'(1))) begin
               rsp_start_q <= 1'b1;
            end
         end
         if (rd_valid_q && rd_ready_i) begin
            rd_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_xfer) begin
         we_q   <= req_we_i;
         addr_q <= req_addr_i;
         src_q  <= req_src_i;
      end
      if (bus_done) begin
         addr_q <= addr_q + mam_pkg::addr_t'(2);
         if (!we_q) begin
            rd_data_q <= dat_i;
         end
      end
   end

   assign cyc_o  = cyc_q;
   assign stb_o  = cyc_q;
   assign we_o   = cyc_q && we_q;
   assign addr_o = addr_q;
   assign dat_o  = wr_data_i;

   // The write word is consumed on the acknowledged edge of its beat
   assign wr_ready_o = bus_done && we_q;

   assign rsp_start_o = rsp_start_q;
   assign rsp_we_o    = we_q;
   assign rsp_dest_o  = src_q;
   assign rd_valid_o  = rd_valid_q;
   assign rd_data_o   = rd_data_q;

   // Strobe stays up with cycle and address until acknowledged
   a_stb_held: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o && !ack_i |=> stb_o && cyc_o && $stable(addr_o));

   // A stray acknowledge outside a cycle moves no beat
   a_ack_ignored: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_i && !cyc_o && !req_xfer |=> $stable(cnt_q));

endmodule

//--- hdl/osd_mam_wb.sv
// Debug memory access module with a Wishbone master; top level joining decode, execute and result
`timescale 1ns/1ps

module osd_mam_wb (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              debug_in_valid_i,
   input  logic              debug_in_last_i,
   input  mam_pkg::flit_t    debug_in_data_i,
   output logic              debug_in_ready_o,
   output logic              debug_out_valid_o,
   output logic              debug_out_last_o,
   output mam_pkg::flit_t    debug_out_data_o,
   input  logic              debug_out_ready_i,
   input  mam_pkg::node_id_t id_i,
   output logic              cyc_o,
   output logic              stb_o,
   output logic              we_o,
   output mam_pkg::addr_t    addr_o,
   output mam_pkg::flit_t    dat_o,
   input  mam_pkg::flit_t    dat_i,
   input  logic              ack_i
);

   logic              req_valid;
   logic              req_ready;
   logic              req_we;
   mam_pkg::addr_t    req_addr;
   mam_pkg::beats_t   req_beats;
   mam_pkg::node_id_t req_src;
   logic              wr_valid;
   logic              wr_ready;
   mam_pkg::flit_t    wr_data;
   logic              rsp_start;
   logic              rsp_we;
   mam_pkg::node_id_t rsp_dest;
   logic              rd_valid;
   logic              rd_ready;
   mam_pkg::flit_t    rd_data;

   mam_req_decode u_decode (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (debug_in_valid_i),
      .in_last_i   (debug_in_last_i),
      .in_data_i   (debug_in_data_i),
      .in_ready_o  (debug_in_ready_o),
      .id_i        (id_i),
      .req_valid_o (req_valid),
      .req_ready_i (req_ready),
      .req_we_o    (req_we),
      .req_addr_o  (req_addr),
      .req_beats_o (req_beats),
      .req_src_o   (req_src),
      .wr_valid_o  (wr_valid),
      .wr_ready_i  (wr_ready),
      .wr_data_o   (wr_data)
   );

   mam_wb_master u_exec (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid),
      .req_ready_o (req_ready),
      .req_we_i    (req_we),
      .req_addr_i  (req_addr),
      .req_beats_i (req_beats),
      .req_src_i   (req_src),
      .wr_valid_i  (wr_valid),
      .wr_ready_o  (wr_ready),
      .wr_data_i   (wr_data),
      .rsp_start_o (rsp_start),
      .rsp_we_o    (rsp_we),
      .rsp_dest_o  (rsp_dest),
      .rd_valid_o  (rd_valid),
      .rd_ready_i  (rd_ready),
      .rd_data_o   (rd_data),
      .cyc_o       (cyc_o),
      .stb_o       (stb_o),
      .we_o        (we_o),
      .addr_o      (addr_o),
      .dat_o       (dat_o),
      .dat_i       (dat_i),
      .ack_i       (ack_i)
   );

   // Latched request count still holds when a read response starts
   mam_resp_encode u_result (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rsp_start_i (rsp_start),
      .rsp_we_i    (rsp_we),
      .rsp_dest_i  (rsp_dest),
      .beats_i     (req_beats),
      .id_i        (id_i),
      .rd_valid_i  (rd_valid),
      .rd_ready_o  (rd_ready),
      .rd_data_i   (rd_data),
      .out_valid_o (debug_out_valid_o),
      .out_ready_i (debug_out_ready_i),
      .out_last_o  (debug_out_last_o),
      .out_data_o  (debug_out_data_o)
   );

endmodule

//--- osd_mam_wb.f
+incdir+hdl
hdl/mam_pkg.sv
hdl/mam_req_decode.sv
hdl/mam_wb_master.sv
hdl/mam_resp_encode.sv
hdl/osd_mam_wb.sv
bench/tb_osd_mam_wb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f osd_mam_wb.f \
   --top-module tb_osd_mam_wb \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "Verification passed" sim.log
